/* vlog.f */
src/cache_pkg.sv
src/main_mem.sv
src/icache.sv
src/dcache.sv
src/cache_fill_ctrl.sv
src/cache_top.sv
sim/tb_cache_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_cache_top \
    -Mdir obj_dir -o tb_cache_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cache_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
exit 0

/* sim/tb_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top import cache_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int MEM_LATENCY  = 4;
    localparam int FILL_CYCLES  = 1 + WORDS_PER_BLOCK + MEM_LATENCY - 1;
    // Two back-to-back fills plus a little slack
    localparam int STALL_BOUND  = 2 * FILL_CYCLES + 4;
    localparam int NUM_ACCESSES = 60;
    localparam int WATCHDOG_NS  = NUM_ACCESSES * STALL_BOUND * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    cache_addr_t i_addr;
    logic [15:0] i_data;
    logic        i_miss;
    cache_addr_t d_addr;
    logic        d_rd;
    logic        d_wr;
    logic [15:0] d_wdata;
    logic [15:0] d_rdata;
    logic        d_miss;
    logic        stall;
    logic        idle;

    // Expected contents of main memory, one entry per word
    logic [15:0] shadow [32768];
    integer      seed;
    int          err_count;
    int          check_count;
    int          test_count;
    int          test_errs_at_start;

    cache_top #(
        .MEM_LATENCY (MEM_LATENCY)
    ) dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_addr  (i_addr),
        .i_data  (i_data),
        .i_miss  (i_miss),
        .d_addr  (d_addr),
        .d_rd    (d_rd),
        .d_wr    (d_wr),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .d_miss  (d_miss),
        .stall   (stall),
        .idle    (idle)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the run took longer than %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic cache_addr_t make_addr(input logic [5:0] tag, input logic [5:0] index,
                                              input logic [2:0] word);
        cache_addr_t a;
        a.f.tag      = tag;
        a.f.index    = index;
        a.f.word     = word;
        a.f.byte_off = 1'b0;
        return a;
    endfunction

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        check_count++;
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h got %h at %0t", name, exp, act, $time);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h got %h at %0t", name, exp, act, $time);
            err_count++;
        end
    endtask

    // Samples at the falling edge, where every output has settled
    task automatic wait_stall_low();
        int cycles;
        cycles = 0;
        while (stall && cycles < STALL_BOUND) begin
            @(posedge clk);
            @(negedge clk);
            cycles++;
        end
        if (stall) begin
            $display("Stall stayed high for more than %0d cycles at %0t", STALL_BOUND, $time);
            err_count++;
        end
    endtask

    task automatic data_read(input cache_addr_t addr, output logic saw_miss);
        @(posedge clk);
        d_addr <= addr;
        d_rd   <= 1'b1;
        @(negedge clk);
        saw_miss = d_miss;
        if (d_miss && !stall) begin
            $display("Stall did not rise with the data miss at %0t", $time);
            err_count++;
        end
        wait_stall_low();
        check_val("d_rdata", shadow[addr.raw[15:1]], d_rdata);
        @(posedge clk);
        d_rd <= 1'b0;
    endtask

    // The write lands at the edge that drops d_wr
    task automatic data_write(input cache_addr_t addr, input logic [15:0] data,
                              output logic saw_miss);
        @(posedge clk);
        d_addr  <= addr;
        d_wdata <= data;
        d_wr    <= 1'b1;
        @(negedge clk);
        saw_miss = d_miss;
        wait_stall_low();
        @(posedge clk);
        d_wr <= 1'b0;
        shadow[addr.raw[15:1]] = data;
    endtask

    task automatic fetch(input cache_addr_t addr, output logic saw_miss);
        @(posedge clk);
        i_addr <= addr;
        @(negedge clk);
        saw_miss = i_miss;
        wait_stall_low();
        check_val("i_data", shadow[addr.raw[15:1]], i_data);
    endtask

    task automatic begin_test();
        test_errs_at_start = err_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == test_errs_at_start) begin
            $display("[%s] pass", name);
        end else begin
            $display("[%s] %0d errors", name, err_count - test_errs_at_start);
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset_cold_read();
        logic missed;
        begin_test();
        // Fetch address is always presented, so the cold icache misses at once
        check_flag("idle", 1'b1, idle);
        check_flag("i_miss", 1'b1, i_miss);
        check_flag("stall", 1'b1, stall);
        // FSM has left IDLE one edge into the fill
        @(posedge clk);
        @(negedge clk);
        check_flag("idle", 1'b0, idle);
        wait_stall_low();
        check_flag("idle", 1'b1, idle);
        check_flag("stall", 1'b0, stall);
        data_read(make_addr(6'd1, 6'd2, 3'd3), missed);
        check_flag("d_miss", 1'b1, missed);
        end_test("reset_cold_read");
    endtask

    task automatic test_write_allocate();
        cache_addr_t a;
        cache_addr_t b;
        logic        missed;
        begin_test();
        a = make_addr(6'd5, 6'd10, 3'd3);
        b = make_addr(6'd9, 6'd10, 3'd3);
        data_write(a, 16'($random(seed)), missed);
        check_flag("d_miss", 1'b1, missed);
        data_read(a, missed);
        check_flag("d_miss", 1'b0, missed);
        // Same index, other tag
        data_read(b, missed);
        check_flag("d_miss", 1'b1, missed);
        data_read(a, missed);
        check_flag("d_miss", 1'b1, missed);
        end_test("write_allocate");
    endtask

    task automatic test_fetch();
        cache_addr_t x0;
        cache_addr_t x1;
        logic        missed;
        begin_test();
        x0 = make_addr(6'd2, 6'd33, 3'd5);
        x1 = make_addr(6'd2, 6'd33, 3'd1);
        data_write(x0, 16'($random(seed)), missed);
        data_write(x1, 16'($random(seed)), missed);
        fetch(x0, missed);
        check_flag("i_miss", 1'b1, missed);
        fetch(x1, missed);
        check_flag("i_miss", 1'b0, missed);
        end_test("fetch");
    endtask

    task automatic test_dual_miss();
        cache_addr_t y;
        cache_addr_t z;
        logic        missed;
        begin_test();
        y = make_addr(6'd3, 6'd40, 3'd2);
        z = make_addr(6'd7, 6'd41, 3'd4);
        data_write(y, 16'($random(seed)), missed);
        @(posedge clk);
        i_addr <= y;
        d_addr <= z;
        d_rd   <= 1'b1;
        @(negedge clk);
        check_flag("i_miss", 1'b1, i_miss);
        check_flag("d_miss", 1'b1, d_miss);
        check_flag("stall", 1'b1, stall);
        wait_stall_low();
        // Both served within one stall window
        check_flag("i_miss", 1'b0, i_miss);
        check_flag("d_miss", 1'b0, d_miss);
        check_val("i_data", shadow[y.raw[15:1]], i_data);
        check_val("d_rdata", shadow[z.raw[15:1]], d_rdata);
        @(posedge clk);
        d_rd <= 1'b0;
        end_test("dual_miss");
    endtask

    task automatic test_random_traffic();
        logic [31:0] r;
        cache_addr_t a;
        logic        missed;
        begin_test();
        for (int n = 0; n < 40; n++) begin
            r = $random(seed);
            // Four neighbouring lines, four tags, two words, so reads revisit writes
            a = make_addr({4'b0000, r[4:3]}, 6'd20 + {4'b0000, r[1:0]}, {2'b00, r[6]});
            if (r[9]) begin
                data_write(a, r[31:16], missed);
            end else begin
                data_read(a, missed);
            end
        end
        end_test("random_traffic");
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        seed               = 32'h13f9_eba3;
        err_count          = 0;
        check_count        = 0;
        test_count         = 0;
        test_errs_at_start = 0;
        for (int i = 0; i < 32768; i++) begin
            shadow[i] = 16'h0000;
        end
        rst_n   <= 1'b0;
        i_addr  <= make_addr(6'd0, 6'd0, 3'd0);
        d_addr  <= '0;
        d_rd    <= 1'b0;
        d_wr    <= 1'b0;
        d_wdata <= 16'h0000;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        test_reset_cold_read();
        test_write_allocate();
        test_fetch();
        test_dual_miss();
        test_random_traffic();

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; #(
    parameter int MEM_LATENCY = 4
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  cache_addr_t      i_addr,
    output logic [15:0]      i_data,
    output logic             i_miss,
    input  cache_addr_t      d_addr,
    input  wire logic        d_rd,
    input  wire logic        d_wr,
    input  wire logic [15:0] d_wdata,
    output logic [15:0]      d_rdata,
    output logic             d_miss,
    output logic             stall,
    output logic             idle
);

    fill_wr_t    i_fill;
    fill_wr_t    d_fill;
    logic        wt_valid;
    cache_addr_t wt_addr;
    logic [15:0] wt_data;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    icache u_icache (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (i_addr),
        .data  (i_data),
        .miss  (i_miss),
        .fill  (i_fill)
    );

    dcache u_dcache (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (d_addr),
        .rd       (d_rd),
        .wr       (d_wr),
        .wdata    (d_wdata),
        .rdata    (d_rdata),
        .miss     (d_miss),
        .fill     (d_fill),
        .wt_valid (wt_valid),
        .wt_addr  (wt_addr),
        .wt_data  (wt_data)
    );

    // Miss addresses are the held core addresses
    cache_fill_ctrl u_fill_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_miss      (i_miss),
        .d_miss      (d_miss),
        .i_miss_addr (i_addr),
        .d_miss_addr (d_addr),
        .wt_valid    (wt_valid),
        .wt_addr     (wt_addr),
        .wt_data     (wt_data),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .i_fill      (i_fill),
        .d_fill      (d_fill),
        .stall       (stall),
        .idle        (idle)
    );

    main_mem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_main_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

`default_nettype wire

/* src/cache_fill_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_fill_ctrl import cache_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        i_miss,
    input  wire logic        d_miss,
    input  cache_addr_t      i_miss_addr,
    input  cache_addr_t      d_miss_addr,
    input  wire logic        wt_valid,
    input  cache_addr_t      wt_addr,
    input  wire logic [15:0] wt_data,
    output mem_req_t         mem_req,
    input  mem_rsp_t         mem_rsp,
    output fill_wr_t         i_fill,
    output fill_wr_t         d_fill,
    output logic             stall,
    output logic             idle
);

    localparam logic [1:0] IDLE   = 2'b00;
    localparam logic [1:0] WAIT_I = 2'b01;
    localparam logic [1:0] WAIT_D = 2'b10;

    logic [1:0]  state;
    logic [1:0]  state_nxt;
    logic        start_fill;
    cache_addr_t blk_nxt;
    cache_addr_t miss_blk;
    cache_addr_t rd_addr;
    logic [3:0]  req_cnt;
    logic [2:0]  fill_cnt;
    logic        in_wait;
    logic        req_issue;
    logic        last_rsp;
    fill_wr_t    fill;

    assign in_wait   = (state == WAIT_I) || (state == WAIT_D);
    // Requests stop once the whole block has been asked for
    assign req_issue = in_wait && (req_cnt < 4'(WORDS_PER_BLOCK));
    assign last_rsp  = in_wait && mem_rsp.valid && (fill_cnt == 3'(WORDS_PER_BLOCK - 1));

    ////////////////////
    // FSM
    ////////////////////

    // Instruction miss wins, a pending data miss follows the instruction fill
    always_comb begin
        state_nxt  = state;
        start_fill = 1'b0;
        blk_nxt    = d_miss_addr;
        case (state)
            IDLE: begin
                if (i_miss) begin
                    state_nxt  = WAIT_I;
                    start_fill = 1'b1;
                    blk_nxt    = i_miss_addr;
                end else if (d_miss) begin
                    state_nxt  = WAIT_D;
                    start_fill = 1'b1;
                end
            end
            WAIT_I: begin
                if (last_rsp) begin
                    state_nxt  = d_miss ? WAIT_D : IDLE;
                    start_fill = d_miss;
                end
            end
            default: begin
                if (last_rsp) begin
                    state_nxt = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            req_cnt  <= '0;
            fill_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (start_fill) begin
                req_cnt  <= '0;
                fill_cnt <= '0;
            end else begin
                if (req_issue) begin
                    req_cnt <= req_cnt + 4'd1;
                end
                if (in_wait && mem_rsp.valid) begin
                    fill_cnt <= fill_cnt + 3'd1;
                end
            end
        end
    end

    // Block address of the miss being served
    always_ff @(posedge clk) begin
        if (start_fill) begin
            miss_blk <= blk_nxt;
        end
    end

    ////////////////////
    // Memory request
    ////////////////////

    always_comb begin
        rd_addr            = miss_blk;
        rd_addr.f.word     = req_cnt[2:0];
        rd_addr.f.byte_off = 1'b0;
    end

    // Write-through hits only reach memory from IDLE
    always_comb begin
        if (state == IDLE) begin
            mem_req = '{en: wt_valid, we: 1'b1, addr: wt_addr.raw, wdata: wt_data};
        end else begin
            mem_req = '{en: req_issue, we: 1'b0, addr: rd_addr.raw, wdata: 16'h0000};
        end
    end

    ////////////////////
    // Fill routing
    ////////////////////

    assign fill = '{data_we: in_wait && mem_rsp.valid, meta_we: last_rsp,
                    word: fill_cnt, data: mem_rsp.data};

    assign i_fill = (state == WAIT_I) ? fill : '0;
    assign d_fill = (state == WAIT_D) ? fill : '0;

    assign stall = in_wait || i_miss || d_miss;
    assign idle  = (state == IDLE);

    // Only one cache is filled at a time
    a_one_fill: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_fill.data_we && d_fill.data_we));

    // Memory returns only belong to a block fill
    a_rsp_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp.valid |-> (state != IDLE));

endmodule

`default_nettype wire

/* src/dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache import cache_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  cache_addr_t      addr,
    input  wire logic        rd,
    input  wire logic        wr,
    input  wire logic [15:0] wdata,
    output logic [15:0]      rdata,
    output logic             miss,
    input  fill_wr_t         fill,
    output logic             wt_valid,
    output cache_addr_t      wt_addr,
    output logic [15:0]      wt_data
);

    localparam int LINES = 64;

    logic [15:0]      data_mem [LINES*WORDS_PER_BLOCK];
    logic [5:0]       tag_mem  [LINES];
    logic [LINES-1:0] valid;
    logic             hit;
    logic             wr_hit;
    logic [8:0]       acc_sel;
    logic [8:0]       fill_sel;

    ////////////////////
    // Lookup
    ////////////////////

    assign hit     = valid[addr.f.index] && (tag_mem[addr.f.index] == addr.f.tag);
    assign acc_sel = {addr.f.index, addr.f.word};
    assign rdata   = data_mem[acc_sel];

    // Miss only counts for a real access
    assign miss   = (rd || wr) && !hit;
    assign wr_hit = wr && hit;

    // Write-through copy of a write hit
    assign wt_valid = wr_hit;
    assign wt_addr  = addr;
    assign wt_data  = wdata;

    ////////////////////
    // Array update
    ////////////////////

    // Line under fill is taken from the held core address
    assign fill_sel = {addr.f.index, fill.word};

    always_ff @(posedge clk) begin
        if (fill.data_we) begin
            data_mem[fill_sel] <= fill.data;
        end else if (wr_hit) begin
            data_mem[acc_sel] <= wdata;
        end
        if (fill.meta_we) begin
            tag_mem[addr.f.index] <= addr.f.tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (fill.meta_we) begin
            valid[addr.f.index] <= 1'b1;
        end
    end

    // A fill never lands on a line that is being written by the core
    a_fill_no_hit: assert property (@(posedge clk) disable iff (!rst_n)
        fill.data_we |-> !wr_hit);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd && wr));

endmodule

`default_nettype wire

/* src/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache import cache_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  cache_addr_t addr,
    output logic [15:0] data,
    output logic        miss,
    input  fill_wr_t    fill
);

    localparam int LINES = 64;

    logic [15:0]      data_mem [LINES*WORDS_PER_BLOCK];
    logic [5:0]       tag_mem  [LINES];
    logic [LINES-1:0] valid;
    logic [8:0]       rd_sel;
    logic [8:0]       wr_sel;

    ////////////////////
    // Lookup
    ////////////////////

    assign rd_sel = {addr.f.index, addr.f.word};
    assign data   = data_mem[rd_sel];
    assign miss   = !(valid[addr.f.index] && (tag_mem[addr.f.index] == addr.f.tag));

    ////////////////////
    // Fill
    ////////////////////

    // Core holds the fetch address during stall, so its index and tag
    // name the line being filled
    assign wr_sel = {addr.f.index, fill.word};

    always_ff @(posedge clk) begin
        if (fill.data_we) begin
            data_mem[wr_sel] <= fill.data;
        end
        if (fill.meta_we) begin
            tag_mem[addr.f.index] <= addr.f.tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (fill.meta_we) begin
            valid[addr.f.index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/main_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module main_mem import cache_pkg::*; #(
    parameter int MEM_LATENCY = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  mem_req_t  req,
    output mem_rsp_t  rsp
);

    localparam int WORDS = 32768;

    logic [15:0]            mem [WORDS];
    logic [MEM_LATENCY-1:0] vld_pipe;
    logic [15:0]            data_pipe [MEM_LATENCY];
    logic [14:0]            word_addr;
    logic                   rd_req;
    logic                   wr_req;

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = 16'h0000;
        end
    end

    assign word_addr = req.addr[15:1];
    assign rd_req    = req.en && !req.we;
    assign wr_req    = req.en && req.we;

    ////////////////////
    // Array and read pipeline
    ////////////////////

    always_ff @(posedge clk) begin
        if (wr_req) begin
            mem[word_addr] <= req.wdata;
        end
        data_pipe[0] <= mem[word_addr];
        for (int s = 1; s < MEM_LATENCY; s++) begin
            data_pipe[s] <= data_pipe[s-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= rd_req;
            for (int s = 1; s < MEM_LATENCY; s++) begin
                vld_pipe[s] <= vld_pipe[s-1];
            end
        end
    end

    assign rsp = '{valid: vld_pipe[MEM_LATENCY-1], data: data_pipe[MEM_LATENCY-1]};

    // Writes come only from IDLE, after every fill read has returned
    a_no_wr_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req |-> !(|vld_pipe));

endmodule

`default_nettype wire

/* src/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // Cache geometry
    localparam int WORDS_PER_BLOCK = 8;

    ////////////////////
    // Address word
    ////////////////////

    // 6-bit tag, 64 lines, 8 words per block, byte select in bit 0
    typedef struct packed {
        logic [5:0] tag;
        logic [5:0] index;
        logic [2:0] word;
        logic       byte_off;
    } cache_addr_fields_t;

    typedef union packed {
        logic [15:0]        raw;
        cache_addr_fields_t f;
    } cache_addr_t;

    ////////////////////
    // Memory port
    ////////////////////

    typedef struct packed {
        logic        en;
        logic        we;
        logic [15:0] addr;
        logic [15:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [15:0] data;
    } mem_rsp_t;

    // One word of a block fill into a cache
    typedef struct packed {
        logic        data_we;
        logic        meta_we;
        logic [2:0]  word;
        logic [15:0] data;
    } fill_wr_t;

endpackage

`default_nettype wire
